// File: design/isa_pkg.sv
// micro-op format, opcode values and architectural register types
`default_nettype none

package isa_pkg;

    localparam int UOP_W     = 16;
    localparam int OPCODE_W  = 4;
    localparam int AREG_W    = 3;
    localparam int NUM_AREGS = 8;

    typedef logic [UOP_W-1:0]    uop_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [AREG_W-1:0]   areg_t;

    // field positions inside a uop
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS1_LSB = 6;
    localparam int RS2_LSB = 3;

    // opcodes 0..11 write rd, these four do not
    localparam opcode_t OP_STORE  = 4'd12;
    localparam opcode_t OP_BRANCH = 4'd13;
    localparam opcode_t OP_FENCE  = 4'd14;
    localparam opcode_t OP_NOP    = 4'd15;

    function automatic logic op_writes_rd(input opcode_t op);
        return !(op inside {OP_STORE, OP_BRANCH, OP_FENCE, OP_NOP});
    endfunction

endpackage

`default_nettype wire

// File: design/rename_pkg.sv
// physical register, ROB tag and group types, reset mapping rule
`default_nettype none

package rename_pkg;

    localparam int PREG_W    = 5;
    localparam int NUM_PREGS = 32;
    localparam int ROB_TAG_W = 5;
    localparam int GROUP_W   = 4;
    localparam int PORTS_W   = 4;

    typedef logic [PREG_W-1:0]    preg_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [NUM_PREGS-1:0] preg_mask_t;

    // one bit per slot, set when the slot takes a destination
    typedef logic [GROUP_W-1:0] alloc_mask_t;

    // selects one of the four pool entries
    typedef logic [$clog2(GROUP_W)-1:0] slot_idx_t;

    // 0 .. GROUP_W destinations in a group
    typedef logic [$clog2(GROUP_W):0] group_count_t;

    // 0 .. NUM_PREGS free registers
    typedef logic [PREG_W:0] pcount_t;

    // arch i sits in phys i and is ready after reset
    localparam preg_mask_t RESET_READY = preg_mask_t'((1 << isa_pkg::NUM_AREGS) - 1);

    // phys 8..31 start in the pool; phys 0 never enters it
    localparam preg_mask_t RESET_FREE = ~RESET_READY;

    function automatic preg_t reset_alias(input int unsigned areg);
        return preg_t'(areg);
    endfunction

endpackage

`default_nettype wire

// File: design/rat.sv
// register alias table with per-physical-register ready bits
`default_nettype none
`timescale 1ns/100ps

module rat (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           commit_group,
    input  rename_pkg::preg_t [isa_pkg::NUM_AREGS-1:0]     new_map,
    input  rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]    alloc_preg,
    input  rename_pkg::alloc_mask_t                        alloc_mask,
    input  logic [rename_pkg::PORTS_W-1:0]                 wb_valid,
    input  rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]    wb_preg,
    output rename_pkg::preg_t [isa_pkg::NUM_AREGS-1:0]     map,
    output rename_pkg::preg_mask_t                         ready_bits
);

    rename_pkg::preg_mask_t ready_next;

    always_comb begin
        ready_next = ready_bits;
        for (int p = 0; p < rename_pkg::PORTS_W; p++) begin
            if (wb_valid[p]) begin
                ready_next[wb_preg[p]] = 1'b1;
            end
        end
        // new destinations go pending, even over a writeback this cycle
        if (commit_group) begin
            for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
                if (alloc_mask[k]) begin
                    ready_next[alloc_preg[k]] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < isa_pkg::NUM_AREGS; i++) begin
                map[i] <= rename_pkg::reset_alias(i);
            end
            ready_bits <= rename_pkg::RESET_READY;
        end else begin
            if (commit_group) begin
                map <= new_map;
            end
            ready_bits <= ready_next;
        end
    end

    // phys 0 backs r0 and is never handed out by the pool
    p0_ready: assert property (
        @(posedge clk) disable iff (rst) ready_bits[0]
    );

endmodule

`default_nettype wire

// File: design/free_list.sv
// bitmap free pool, lowest-first pick of four, commit release
`default_nettype none
`timescale 1ns/100ps

module free_list (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           commit_group,
    input  rename_pkg::alloc_mask_t                        alloc_mask,
    input  logic [rename_pkg::PORTS_W-1:0]                 cm_valid,
    input  rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]    cm_preg,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]    alloc_preg,
    output rename_pkg::pcount_t                            free_count
);

    rename_pkg::preg_mask_t   free_bits;
    rename_pkg::preg_mask_t   free_next;
    rename_pkg::group_count_t pick_n;
    rename_pkg::group_count_t used;

    // scan upward, first four free bits go to the pool entries
    always_comb begin
        alloc_preg = '0;
        pick_n = '0;
        free_count = '0;
        for (int i = 0; i < rename_pkg::NUM_PREGS; i++) begin
            if (free_bits[i]) begin
                if (pick_n < rename_pkg::GROUP_W) begin
                    alloc_preg[rename_pkg::slot_idx_t'(pick_n)] = rename_pkg::preg_t'(i);
                    pick_n = pick_n + 1'b1;
                end
                free_count = free_count + 1'b1;
            end
        end
    end

    always_comb begin
        used = '0;
        for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
            used = used + rename_pkg::group_count_t'(alloc_mask[k]);
        end
        free_next = free_bits;
        // writing slots take the lowest entries in order
        if (commit_group) begin
            for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
                if (k < used) begin
                    free_next[alloc_preg[k]] = 1'b0;
                end
            end
        end
        for (int p = 0; p < rename_pkg::PORTS_W; p++) begin
            if (cm_valid[p]) begin
                free_next[cm_preg[p]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_bits <= rename_pkg::RESET_FREE;
        end else begin
            free_bits <= free_next;
        end
    end

    for (genvar p = 0; p < rename_pkg::PORTS_W; p++) begin : g_release_chk
        release_not_free: assert property (
            @(posedge clk) disable iff (rst) cm_valid[p] |-> !free_bits[cm_preg[p]]
        );
        release_not_p0: assert property (
            @(posedge clk) disable iff (rst) cm_valid[p] |-> cm_preg[p] != '0
        );
    end

endmodule

`default_nettype wire

// File: design/rename_slot.sv
// combinational rename of one micro-op, chained from earlier slots
`default_nettype none
`timescale 1ns/100ps

module rename_slot (
    input  isa_pkg::uop_t                               uop,
    input  rename_pkg::preg_t [isa_pkg::NUM_AREGS-1:0]  map_in,
    input  logic [isa_pkg::NUM_AREGS-1:0]               prod_in,
    input  rename_pkg::preg_t                           pool_preg,
    input  rename_pkg::preg_mask_t                      ready_bits,
    output rename_pkg::preg_t [isa_pkg::NUM_AREGS-1:0]  map_out,
    output logic [isa_pkg::NUM_AREGS-1:0]               prod_out,
    output logic                                        writes,
    output rename_pkg::preg_t                           pd,
    output rename_pkg::preg_t                           ps1,
    output rename_pkg::preg_t                           ps2,
    output logic                                        ps1_ready,
    output logic                                        ps2_ready,
    output rename_pkg::preg_t                           old_pd
);

    isa_pkg::opcode_t opcode;
    isa_pkg::areg_t   rd;
    isa_pkg::areg_t   rs1;
    isa_pkg::areg_t   rs2;

    assign opcode = uop[isa_pkg::OPC_LSB +: isa_pkg::OPCODE_W];
    assign rd     = uop[isa_pkg::RD_LSB +: isa_pkg::AREG_W];
    assign rs1    = uop[isa_pkg::RS1_LSB +: isa_pkg::AREG_W];
    assign rs2    = uop[isa_pkg::RS2_LSB +: isa_pkg::AREG_W];

    // r0 is hardwired, never takes a pool register
    assign writes = isa_pkg::op_writes_rd(opcode) && (rd != '0);

    assign ps1 = map_in[rs1];
    assign ps2 = map_in[rs2];

    // produced earlier in this group means not ready yet
    assign ps1_ready = (rs1 == '0) || (ready_bits[ps1] && !prod_in[rs1]);
    assign ps2_ready = (rs2 == '0) || (ready_bits[ps2] && !prod_in[rs2]);

    assign pd     = writes ? pool_preg : '0;
    assign old_pd = writes ? map_in[rd] : '0;

    always_comb begin
        map_out  = map_in;
        prod_out = prod_in;
        if (writes) begin
            map_out[rd]  = pool_preg;
            prod_out[rd] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/rename_ctrl.sv
// group handshake, pool shortage stall, output register and ROB tag counter
`default_nettype none
`timescale 1ns/100ps

module rename_ctrl (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             in_valid,
    input  isa_pkg::uop_t [rename_pkg::GROUP_W-1:0]          in_uops,
    input  logic                                             out_ready,
    input  rename_pkg::pcount_t                              free_count,
    input  rename_pkg::alloc_mask_t                          alloc_mask,
    input  rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      slot_pd,
    input  rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      slot_ps1,
    input  rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      slot_ps2,
    input  logic [rename_pkg::GROUP_W-1:0]                   slot_ps1_ready,
    input  logic [rename_pkg::GROUP_W-1:0]                   slot_ps2_ready,
    input  rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      slot_old_pd,
    output logic                                             in_ready,
    output logic                                             commit_group,
    output rename_pkg::slot_idx_t [rename_pkg::GROUP_W-1:0]  pool_index,
    output logic                                             out_valid,
    output isa_pkg::opcode_t [rename_pkg::GROUP_W-1:0]       out_opcode,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      out_pd,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      out_ps1,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      out_ps2,
    output logic [rename_pkg::GROUP_W-1:0]                   out_ps1_ready,
    output logic [rename_pkg::GROUP_W-1:0]                   out_ps2_ready,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]      out_old_pd,
    output rename_pkg::alloc_mask_t                          out_writes,
    output rename_pkg::rob_tag_t [rename_pkg::GROUP_W-1:0]   out_tag
);

    rename_pkg::group_count_t dest_count;
    rename_pkg::rob_tag_t     tag_q;
    logic                     out_free;

    // running count of writers gives each slot its pool entry
    always_comb begin
        dest_count = '0;
        for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
            pool_index[k] = rename_pkg::slot_idx_t'(dest_count);
            dest_count = dest_count + rename_pkg::group_count_t'(alloc_mask[k]);
        end
    end

    assign out_free     = !out_valid || out_ready;
    assign in_ready     = out_free && (free_count >= rename_pkg::pcount_t'(dest_count));
    assign commit_group = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tag_q     <= '0;
        end else begin
            if (commit_group) begin
                out_valid <= 1'b1;
                tag_q     <= tag_q + rename_pkg::rob_tag_t'(rename_pkg::GROUP_W);
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // payload only moves when a new group is taken
    always_ff @(posedge clk) begin
        if (commit_group) begin
            for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
                out_opcode[k] <= in_uops[k][isa_pkg::OPC_LSB +: isa_pkg::OPCODE_W];
                out_tag[k]    <= tag_q + rename_pkg::rob_tag_t'(k);
            end
            out_pd        <= slot_pd;
            out_ps1       <= slot_ps1;
            out_ps2       <= slot_ps2;
            out_ps1_ready <= slot_ps1_ready;
            out_ps2_ready <= slot_ps2_ready;
            out_old_pd    <= slot_old_pd;
            out_writes    <= alloc_mask;
        end
    end

    // a stalled group stays put, tags included
    out_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_tag) && $stable(out_pd)
    );

endmodule

`default_nettype wire

// File: design/rename_top.sv
// rename stage top level: control, alias table, free pool and four slots
`default_nettype none
`timescale 1ns/100ps

module rename_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            in_valid,
    input  isa_pkg::uop_t [rename_pkg::GROUP_W-1:0]         in_uops,
    output logic                                            in_ready,
    output logic                                            out_valid,
    output isa_pkg::opcode_t [rename_pkg::GROUP_W-1:0]      out_opcode,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_pd,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_ps1,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_ps2,
    output logic [rename_pkg::GROUP_W-1:0]                  out_ps1_ready,
    output logic [rename_pkg::GROUP_W-1:0]                  out_ps2_ready,
    output rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_old_pd,
    output rename_pkg::alloc_mask_t                         out_writes,
    output rename_pkg::rob_tag_t [rename_pkg::GROUP_W-1:0]  out_tag,
    input  logic                                            out_ready,
    input  logic [rename_pkg::PORTS_W-1:0]                  wb_valid,
    input  rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]     wb_preg,
    input  logic [rename_pkg::PORTS_W-1:0]                  cm_valid,
    input  rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]     cm_preg
);

    // alias view after each slot, entry 0 is the table itself
    rename_pkg::preg_t [rename_pkg::GROUP_W:0][isa_pkg::NUM_AREGS-1:0] map_chain;
    logic [rename_pkg::GROUP_W:0][isa_pkg::NUM_AREGS-1:0]              prod_chain;

    rename_pkg::preg_mask_t                             ready_bits;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        alloc_preg;
    rename_pkg::pcount_t                                free_count;
    rename_pkg::alloc_mask_t                            alloc_mask;
    rename_pkg::slot_idx_t [rename_pkg::GROUP_W-1:0]    pool_index;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        pool_preg;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        slot_pd;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        slot_ps1;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        slot_ps2;
    logic [rename_pkg::GROUP_W-1:0]                     slot_ps1_ready;
    logic [rename_pkg::GROUP_W-1:0]                     slot_ps2_ready;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]        slot_old_pd;
    logic                                               commit_group;

    assign prod_chain[0] = '0;

    for (genvar k = 0; k < rename_pkg::GROUP_W; k++) begin : g_slot
        assign pool_preg[k] = alloc_preg[pool_index[k]];

        rename_slot u_rename_slot (
            .uop        (in_uops[k]),
            .map_in     (map_chain[k]),
            .prod_in    (prod_chain[k]),
            .pool_preg  (pool_preg[k]),
            .ready_bits (ready_bits),
            .map_out    (map_chain[k+1]),
            .prod_out   (prod_chain[k+1]),
            .writes     (alloc_mask[k]),
            .pd         (slot_pd[k]),
            .ps1        (slot_ps1[k]),
            .ps2        (slot_ps2[k]),
            .ps1_ready  (slot_ps1_ready[k]),
            .ps2_ready  (slot_ps2_ready[k]),
            .old_pd     (slot_old_pd[k])
        );
    end

    rat u_rat (
        .clk          (clk),
        .rst          (rst),
        .commit_group (commit_group),
        .new_map      (map_chain[rename_pkg::GROUP_W]),
        .alloc_preg   (pool_preg),
        .alloc_mask   (alloc_mask),
        .wb_valid     (wb_valid),
        .wb_preg      (wb_preg),
        .map          (map_chain[0]),
        .ready_bits   (ready_bits)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .commit_group (commit_group),
        .alloc_mask   (alloc_mask),
        .cm_valid     (cm_valid),
        .cm_preg      (cm_preg),
        .alloc_preg   (alloc_preg),
        .free_count   (free_count)
    );

    rename_ctrl u_rename_ctrl (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_uops        (in_uops),
        .out_ready      (out_ready),
        .free_count     (free_count),
        .alloc_mask     (alloc_mask),
        .slot_pd        (slot_pd),
        .slot_ps1       (slot_ps1),
        .slot_ps2       (slot_ps2),
        .slot_ps1_ready (slot_ps1_ready),
        .slot_ps2_ready (slot_ps2_ready),
        .slot_old_pd    (slot_old_pd),
        .in_ready       (in_ready),
        .commit_group   (commit_group),
        .pool_index     (pool_index),
        .out_valid      (out_valid),
        .out_opcode     (out_opcode),
        .out_pd         (out_pd),
        .out_ps1        (out_ps1),
        .out_ps2        (out_ps2),
        .out_ps1_ready  (out_ps1_ready),
        .out_ps2_ready  (out_ps2_ready),
        .out_old_pd     (out_old_pd),
        .out_writes     (out_writes),
        .out_tag        (out_tag)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// clock and reset source for the testbench
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset spans the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_rename_top.sv
// rename stage testbench with case file driver, output checker and timeout
`default_nettype none
`timescale 1ns/100ps

module tb_rename_top;

    logic                                            clk;
    logic                                            rst;
    logic                                            in_valid;
    isa_pkg::uop_t [rename_pkg::GROUP_W-1:0]         in_uops;
    logic                                            in_ready;
    logic                                            out_valid;
    isa_pkg::opcode_t [rename_pkg::GROUP_W-1:0]      out_opcode;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_pd;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_ps1;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_ps2;
    logic [rename_pkg::GROUP_W-1:0]                  out_ps1_ready;
    logic [rename_pkg::GROUP_W-1:0]                  out_ps2_ready;
    rename_pkg::preg_t [rename_pkg::GROUP_W-1:0]     out_old_pd;
    rename_pkg::alloc_mask_t                         out_writes;
    rename_pkg::rob_tag_t [rename_pkg::GROUP_W-1:0]  out_tag;
    logic                                            out_ready;
    logic [rename_pkg::PORTS_W-1:0]                  wb_valid;
    rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]     wb_preg;
    logic [rename_pkg::PORTS_W-1:0]                  cm_valid;
    rename_pkg::preg_t [rename_pkg::PORTS_W-1:0]     cm_preg;

    logic [15:0] cases [0:255];
    int          expect_q [$];
    int          cycle_limit = 1000;
    int          cycle_count = 0;
    int          next_tag = 0;
    logic        hold_ready = 1'b0;
    logic [31:0] rng_state = 32'd66288;

    tb_clock_gen u_tb_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    rename_top u_rename_top (
        .clk (clk), .rst (rst), .in_valid (in_valid), .in_uops (in_uops),
        .in_ready (in_ready), .out_valid (out_valid), .out_opcode (out_opcode),
        .out_pd (out_pd), .out_ps1 (out_ps1), .out_ps2 (out_ps2),
        .out_ps1_ready (out_ps1_ready), .out_ps2_ready (out_ps2_ready),
        .out_old_pd (out_old_pd), .out_writes (out_writes), .out_tag (out_tag),
        .out_ready (out_ready), .wb_valid (wb_valid), .wb_preg (wb_preg),
        .cm_valid (cm_valid), .cm_preg (cm_preg)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // walks the records and returns -1 on an unknown kind
    function automatic int count_records();
        int at;
        int n;
        at = 0;
        n = 0;
        while (at < 256 && cases[at] != 16'h0) begin
            n++;
            case (cases[at])
                16'h1: at += 25;
                16'h2, 16'h3: at += 6;
                16'h4: at += 5;
                default: return -1;
            endcase
        end
        return n;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp)
        else abort_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic send_group(input int at);
        in_valid = 1'b1;
        for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
            in_uops[k] = cases[at + 1 + k];
        end
        expect_q.push_back(at);
        do begin
            @(posedge clk);
        end while (!in_ready);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // kind 2 is a writeback list and kind 3 a commit list
    task automatic pulse_ports(input int kind, input int at);
        logic [rename_pkg::PORTS_W-1:0] mask;
        mask = cases[at + 1][rename_pkg::PORTS_W-1:0];
        for (int p = 0; p < rename_pkg::PORTS_W; p++) begin
            if (kind == 2) begin
                wb_preg[p] = rename_pkg::preg_t'(cases[at + 2 + p]);
            end else begin
                cm_preg[p] = rename_pkg::preg_t'(cases[at + 2 + p]);
            end
        end
        if (kind == 2) begin
            wb_valid = mask;
        end else begin
            cm_valid = mask;
        end
        @(negedge clk);
        wb_valid = '0;
        cm_valid = '0;
    endtask

    // output side held open so only the pool can hold in_ready low
    task automatic check_stall(input int at);
        @(posedge clk);
        hold_ready = 1'b1;
        @(negedge clk);
        in_valid = 1'b1;
        for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
            in_uops[k] = cases[at + 1 + k];
        end
        repeat (3) begin
            @(posedge clk);
            assert (!in_ready)
            else abort_run("a group was accepted although the free pool was too small");
        end
        hold_ready = 1'b0;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic compare_group();
        int    at;
        int    base;
        string ctx;
        assert (expect_q.size() != 0)
        else abort_run("the DUT delivered a group that was never sent");
        at = expect_q.pop_front();
        for (int k = 0; k < rename_pkg::GROUP_W; k++) begin
            base = at + 5 + 5 * k;
            ctx = $sformatf("group at word %0d slot %0d", at, k);
            check_value(out_opcode[k], cases[at + 1 + k][15:12], {ctx, " opcode"});
            check_value(out_pd[k], cases[base], {ctx, " pd"});
            check_value(out_old_pd[k], cases[base + 1], {ctx, " old pd"});
            check_value(out_ps1[k], cases[base + 2], {ctx, " ps1"});
            check_value(out_ps2[k], cases[base + 3], {ctx, " ps2"});
            check_value({out_ps1_ready[k], out_ps2_ready[k]}, cases[base + 4],
                        {ctx, " ready bits"});
            check_value(out_writes[k], cases[base] != 16'h0, {ctx, " writes"});
            check_value(out_tag[k], (next_tag + k) % 32, {ctx, " tag"});
        end
        next_tag = (next_tag + 4) % 32;
    endtask

    always @(negedge clk) begin
        rng_state = xorshift32(rng_state);
        out_ready = !rst && (hold_ready || rng_state[7]);
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            compare_group();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        int at;
        int kind;
        int records;
        in_valid = 1'b0;
        in_uops = '0;
        out_ready = 1'b0;
        wb_valid = '0;
        wb_preg = '0;
        cm_valid = '0;
        cm_preg = '0;
        $readmemh("testbench/rename_cases.txt", cases);
        records = count_records();
        if (records <= 0) begin
            abort_run("the case file is missing or holds an unknown record kind");
        end
        cycle_limit = 20 * records + 100;
        @(negedge rst);
        @(negedge clk);
        at = 0;
        kind = cases[0];
        while (kind != 0) begin
            if (kind == 1) begin
                send_group(at);
                at += 25;
            end else if (kind == 4) begin
                check_stall(at);
                at += 5;
            end else begin
                pulse_ports(kind, at);
                at += 6;
            end
            kind = cases[at];
        end
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        if (!out_valid) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("the DUT holds an extra group after all groups were checked");
        end
    end

endmodule

`default_nettype wire

// File: sim.f
design/isa_pkg.sv
design/rename_pkg.sv
design/rat.sv
design/free_list.sv
design/rename_slot.sv
design/rename_ctrl.sv
design/rename_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rename_top.sv

// File: testbench/rename_cases.txt
// kind 1 group: uop0..uop3, then per slot pd old_pd ps1 ps2 ready(ps1<<1|ps2)
// kind 2 writeback / kind 3 commit: port mask, preg0..preg3
// kind 4 group that must stall: uop0..uop3; kind 0 ends the file
1 1370 1578 17B8 1828
08 01 05 06 3  09 02 05 07 3  0A 03 06 07 3  0B 04 00 05 3
// chained sources, a store and an rd 0 write
1 1A50 C15B 1170 1D70
0C 05 08 09 0  00 00 0C 0A 0  00 00 0C 06 1  0D 06 0C 06 1
2 7 08 09 0C 00
1 2E50 3358 F1C8 1470
0E 07 08 09 3  0F 08 0C 0A 2  00 00 0E 0F 0  10 09 0F 0D 0
// drain the pool down to three
1 1600 1800 1A00 1C00
11 0A 00 00 3  12 0B 00 00 3  13 0C 00 00 3  14 0D 00 00 3
1 1600 1800 1A00 1C00
15 11 00 00 3  16 12 00 00 3  17 13 00 00 3  18 14 00 00 3
1 1600 1800 1A00 1C00
19 15 00 00 3  1A 16 00 00 3  1B 17 00 00 3  1C 18 00 00 3
4 1600 1800 1A00 1C00
3 F 11 0A 0B 08
// lowest released registers come back first
1 1600 1800 1A00 1C00
08 19 00 00 3  0A 1A 00 00 3  0B 1B 00 00 3  11 1C 00 00 3
1 1EE0 C1F0 D010 13C0
1D 0E 08 0A 0  00 00 1D 11 0  00 00 00 10 2  1E 0F 1D 00 1
// tag wraps to 0 here
1 F000 1078 44A8 E080
00 00 00 00 3  00 00 1E 1D 0  1F 10 10 0B 0  00 00 1F 00 1
0
